//--- bench/cv_bus_stimulus.txt
# name op addr wdata exp_rdata exp_cart_a strobe max_gap
# op mr/mw memory read/write, ir/iw I/O read/write, m1 fetch; cart_a "-" is not checked
bios_rd_0000    mr 0000 00 3c -     bios   3
bios_rd_1a5b    mr 1a5b 00 67 -     bios   3
unmapped_2000   mr 2000 00 ff -     none   3
unmapped_4abc   mr 4abc 00 ff -     none   2
bios_wr_0100    mw 0100 77 ff -     none   2
ram_wr_6005     mw 6005 a5 ff -     ram_wr 3
ram_rd_7c05     mr 7c05 00 a5 -     ram_rd 3
ram_wr_63ff     mw 63ff 3c ff -     ram_wr 2
ram_rd_7fff     mr 7fff 00 3c -     ram_rd 2
cart_fix_8000   mr 8000 00 07 1c000 cart   3
cart_fix_bfff   mr bfff 00 f8 1ffff cart   2
cart_pg0_c010   mr c010 00 10 00010 cart   2
page_sel_ffc3   mr ffc3 00 c3 03fc3 cart   2
cart_pg3_c010   mr c010 00 13 0c010 cart   3
page_sel_ffcd   mr ffcd 00 ce 0ffcd cart   1
cart_pg5_e123   mr e123 00 26 16123 cart   1
cart_fix_9234   mr 9234 00 33 1d234 cart   2
cart_wr_8000    mw 8000 11 ff -     none   2
cart_wr_ffc2    mw ffc2 22 ff -     none   2
cart_pg5_c000   mr c000 00 05 14000 cart   2
vdp_wr_bf       iw 00bf 5a ff -     vdp_w  3
vdp_rd_be       ir 00be 00 40 -     vdp_r  3
vdp_rd_a1       ir 00a1 00 41 -     vdp_r  2
psg_wr_ff       iw 00ff 9f ff -     psg    3
ctrl_rd_fc      ir 00fc 00 5f -     ctrl   3
ctrl_rd_12e0    ir 12e0 00 5f -     ctrl   2
io_rd_40        ir 0040 00 ff -     none   2
io_wr_40        iw 0040 33 ff -     none   2
m1_bios_0000    m1 0000 00 3c -     bios   3
m1_bios_1234    m1 1234 00 08 -     bios   3
m1_cart_8001    m1 8001 00 06 1c001 cart   3
b2b_bios_0011   mr 0011 00 2d -     bios   0
b2b_ram_wr_6010 mw 6010 c7 ff -     ram_wr 0
b2b_ram_rd_6010 mr 6010 00 c7 -     ram_rd 0
b2b_cart_a000   mr a000 00 07 1e000 cart   0
b2b_vdp_rd_bd   ir 00bd 00 41 -     vdp_r  0
b2b_ctrl_rd_e0  ir 00e0 00 5f -     ctrl   0
b2b_m1_0020     m1 0020 00 1c -     bios   0
b2b_bios_1fff   mr 1fff 00 c3 -     bios   0
b2b_unmap_5000  mr 5000 00 ff -     none   0
b2b_page_ffc1   mr ffc1 00 c4 17fc1 cart   0
b2b_cart_d0f0   mr d0f0 00 f1 050f0 cart   0
final_bios_0abc mr 0abc 00 80 -     bios   1

//--- tb.f
src/cv_bus_pkg.sv
src/cv_req_stage.sv
src/cv_addr_decode.sv
src/cv_read_merge.sv
src/cv_bus_top.sv
bench/tb_clock_gen.sv
bench/tb_cv_bus.sv

//--- Bender.yml
package:
  name: cv_bus
  description: "Colecovision bus pipeline with testbench"

sources:
  # RTL in compile order
  - src/cv_bus_pkg.sv
  - src/cv_req_stage.sv
  - src/cv_addr_decode.sv
  - src/cv_read_merge.sv
  - src/cv_bus_top.sv
  # Testbench
  - target: test
    files:
      - bench/tb_clock_gen.sv
      - bench/tb_cv_bus.sv

//--- bench/tb_cv_bus.sv
// Run from the project root so the stimulus file is found; the cartridge is fixed at 8 pages
`timescale 1ns/1ps

module tb_cv_bus;

  import cv_bus_pkg::*;

  logic                clk_i;
  logic                reset_n_s;
  logic                req_valid_i;
  logic                req_ready_o;
  logic [addr_w-1:0]   req_addr_i;
  logic                req_io_i;
  logic                req_wr_i;
  logic                req_m1_i;
  logic [data_w-1:0]   req_wdata_i;
  logic                resp_valid_o;
  logic [data_w-1:0]   resp_rdata_o;
  logic [page_w-1:0]   cart_pages_i;
  logic                bios_ce_n_o;
  logic [bios_a_w-1:0] bios_a_o;
  logic [data_w-1:0]   bios_d_i;
  logic                ram_ce_n_o;
  logic                ram_we_n_o;
  logic [ram_a_w-1:0]  ram_a_o;
  logic [data_w-1:0]   ram_d_i;
  logic                cart_ce_n_o;
  logic [cart_a_w-1:0] cart_a_o;
  logic [data_w-1:0]   cart_d_i;
  logic                vdp_r_n_o;
  logic                vdp_w_n_o;
  logic                vdp_mode_o;
  logic [data_w-1:0]   vdp_d_i;
  logic                psg_we_n_o;
  logic                ctrl_r_n_o;
  logic [data_w-1:0]   ctrl_d_i;
  logic [data_w-1:0]   periph_d_o;

  // Requests as read from the file
  string       t_name[$];
  string       t_op[$];
  logic [15:0] t_addr[$];
  logic [7:0]  t_wdata[$];
  logic [7:0]  t_rdata[$];
  logic [19:0] t_cart[$];
  bit          t_cart_chk[$];
  logic [7:0]  t_strobe[$];
  int          t_gap[$];

  // Scoreboard, request index and edge of the expected event
  int resp_idx_q[$];
  int resp_edge_q[$];
  int strb_idx_q[$];
  int strb_edge_q[$];

  logic [7:0] ram_mem [0:1023];
  int         edge_cnt;
  int         m1_block_edge;
  int         val_errors;
  int         other_errors;
  integer     seed;
  bit         loaded;

  tb_clock_gen i_clock_gen (.clk_o(clk_i), .reset_n_o(reset_n_s));

  cv_bus_top i_dut (.*);

  // Rising edges since time zero
  always @(posedge clk_i)
    edge_cnt <= edge_cnt + 1;

  // --------------------
  // Device models
  // --------------------
  // Strobe sampled at the edge that ends it, data valid from that edge
  always @(posedge clk_i)
  begin
    if (!bios_ce_n_o)
      bios_d_i <= bios_a_o[7:0] ^ 8'h3C;
    if (!ram_ce_n_o && !ram_we_n_o)
      ram_mem[ram_a_o] <= periph_d_o;
    else if (!ram_ce_n_o)
      ram_d_i <= ram_mem[ram_a_o];
    if (!cart_ce_n_o)
      cart_d_i <= cart_a_o[7:0] ^ {2'b00, cart_a_o[19:14]};
    if (!vdp_r_n_o)
      vdp_d_i <= 8'h40 + {7'b0000000, vdp_mode_o};
    if (!ctrl_r_n_o)
      ctrl_d_i <= 8'h5F;
  end

  task automatic compare_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected)
    begin
      val_errors++;
      $display("ERR %s %s expected %0h actual %0h", test, what, expected, actual);
    end
  endtask

  // Active-high strobe set per name, same order as the monitor vector
  function automatic logic [7:0] strobe_bits(input string name);
    case (name)
      "none":   return 8'h00;
      "bios":   return 8'h01;
      "ram_rd": return 8'h02;
      "ram_wr": return 8'h06;
      "cart":   return 8'h08;
      "vdp_r":  return 8'h10;
      "vdp_w":  return 8'h20;
      "psg":    return 8'h40;
      "ctrl":   return 8'h80;
      default:  return 8'hFF;
    endcase
  endfunction

  function automatic bit known_op(input string op);
    return op == "mr" || op == "mw" || op == "ir" || op == "iw" || op == "m1";
  endfunction

  // --------------------
  // Stimulus file
  // --------------------
  task automatic load_stimulus();
    int          fd;
    int          n;
    int          line_no;
    string       line;
    string       name;
    string       op;
    string       cart;
    string       strobe;
    logic [15:0] addr;
    logic [7:0]  wdata;
    logic [7:0]  rdata;
    logic [19:0] cart_a;
    int          gap;
    fd = $fopen("bench/cv_bus_stimulus.txt", "r");
    if (fd == 0)
    begin
      other_errors++;
      $display("Cannot open the stimulus file bench/cv_bus_stimulus.txt");
      return;
    end
    line_no = 0;
    while ($fgets(line, fd) != 0)
    begin
      line_no++;
      // Comments and blank lines
      if (line.len() < 2 || line.getc(0) == "#")
        continue;
      n = $sscanf(line, "%s %s %h %h %h %s %s %d",
                  name, op, addr, wdata, rdata, cart, strobe, gap);
      if (n != 8 || !known_op(op) || strobe_bits(strobe) == 8'hFF)
      begin
        other_errors++;
        $display("Stimulus line %0d could not be parsed", line_no);
        continue;
      end
      cart_a = '0;
      if (cart != "-")
        n = $sscanf(cart, "%h", cart_a);
      t_name.push_back(name);
      t_op.push_back(op);
      t_addr.push_back(addr);
      t_wdata.push_back(wdata);
      t_rdata.push_back(rdata);
      t_cart.push_back(cart_a);
      t_cart_chk.push_back(cart != "-");
      t_strobe.push_back(strobe_bits(strobe));
      t_gap.push_back(gap);
    end
    $fclose(fd);
  endtask

  // Random idle gap up to the line's limit, then hold until accepted
  task automatic send_request(input int idx);
    int gap;
    gap = ($random(seed) & 32'h7FFF_FFFF) % (t_gap[idx] + 1);
    repeat (gap)
    begin
      @(posedge clk_i);
      req_valid_i <= 1'b0;
    end
    @(posedge clk_i);
    req_valid_i <= 1'b1;
    req_addr_i  <= t_addr[idx];
    req_io_i    <= (t_op[idx] == "ir" || t_op[idx] == "iw");
    req_wr_i    <= (t_op[idx] == "mw" || t_op[idx] == "iw");
    req_m1_i    <= (t_op[idx] == "m1");
    req_wdata_i <= t_wdata[idx];
    @(negedge clk_i);
    while (!req_ready_o)
      @(negedge clk_i);
    // Accepted at the coming edge
    resp_idx_q.push_back(idx);
    resp_edge_q.push_back(edge_cnt + 1);
    strb_idx_q.push_back(idx);
    if (t_op[idx] == "m1")
    begin
      strb_edge_q.push_back(edge_cnt + 3);
      m1_block_edge = edge_cnt + 1;
    end
    else
      strb_edge_q.push_back(edge_cnt + 2);
  endtask

  // --------------------
  // Monitors
  // --------------------
  task automatic inspect_strobes();
    logic [7:0] act;
    int         idx;
    act = {~ctrl_r_n_o, ~psg_we_n_o, ~vdp_w_n_o, ~vdp_r_n_o,
           ~cart_ce_n_o, ~ram_we_n_o, ~ram_ce_n_o, ~bios_ce_n_o};
    if (strb_edge_q.size() != 0 && strb_edge_q[0] == edge_cnt)
    begin
      idx = strb_idx_q.pop_front();
      strb_edge_q.delete(0);
      compare_value(t_name[idx], "strobes", t_strobe[idx], act);
      if (t_cart_chk[idx])
        compare_value(t_name[idx], "cart_a", t_cart[idx], cart_a_o);
      if (act[0])
        compare_value(t_name[idx], "bios_a", t_addr[idx][12:0], bios_a_o);
      if (act[1])
        compare_value(t_name[idx], "ram_a", t_addr[idx][9:0], ram_a_o);
      if (act[4] || act[5])
        compare_value(t_name[idx], "vdp_mode", t_addr[idx][0], vdp_mode_o);
      if (t_op[idx] == "mw" || t_op[idx] == "iw")
        compare_value(t_name[idx], "periph_d", t_wdata[idx], periph_d_o);
    end
    else
      compare_value("idle", "strobes", 8'h00, act);
  endtask

  task automatic match_response();
    int idx;
    int acc;
    if (!resp_valid_o)
      return;
    if (resp_idx_q.size() == 0)
    begin
      other_errors++;
      $display("Response with no request pending at edge %0d", edge_cnt);
      return;
    end
    idx = resp_idx_q.pop_front();
    acc = resp_edge_q.pop_front();
    compare_value(t_name[idx], "rdata", t_rdata[idx], resp_rdata_o);
    compare_value(t_name[idx], "latency", (t_op[idx] == "m1") ? 4 : 3, edge_cnt - acc);
  endtask

  // Outputs sampled mid-cycle
  always @(negedge clk_i)
  begin
    if (reset_n_s && loaded)
    begin
      compare_value("m1_wait", "req_ready", (edge_cnt == m1_block_edge) ? 0 : 1, req_ready_o);
      inspect_strobes();
      match_response();
    end
  end

  // Watchdog sized from the number of requests
  initial
  begin
    wait (loaded);
    repeat (t_name.size() * 10 + 200) @(posedge clk_i);
    $display("Run timed out after %0d cycles", t_name.size() * 10 + 200);
    $display(">>> FAIL");
    $finish;
  end

  // --------------------
  // Main sequence
  // --------------------
  initial
  begin
    seed          = 49;
    edge_cnt      = 0;
    m1_block_edge = -1;
    val_errors    = 0;
    other_errors  = 0;
    loaded        = 1'b0;
    req_valid_i   = 1'b0;
    req_addr_i    = '0;
    req_io_i      = 1'b0;
    req_wr_i      = 1'b0;
    req_m1_i      = 1'b0;
    req_wdata_i   = '0;
    cart_pages_i  = 6'h07;
    bios_d_i      = 8'hFF;
    ram_d_i       = 8'hFF;
    cart_d_i      = 8'hFF;
    vdp_d_i       = 8'hFF;
    ctrl_d_i      = 8'hFF;
    // RAM fill depends on all ten address bits
    for (int i = 0; i < 1024; i++)
      ram_mem[i] = i[7:0] ^ {6'b000000, i[9:8]};
    load_stimulus();
    if (t_name.size() == 0)
    begin
      other_errors++;
      $display("No requests were read from the stimulus file");
    end
    loaded = 1'b1;
    wait (reset_n_s === 1'b1);
    @(negedge clk_i);
    compare_value("reset", "resp_valid", 0, resp_valid_o);
    for (int i = 0; i < t_name.size(); i++)
      send_request(i);
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    while (resp_idx_q.size() != 0)
      @(negedge clk_i);
    repeat (4) @(negedge clk_i);
    $display("Errors: %0d (%0d value mismatches, %0d other)",
             val_errors + other_errors, val_errors, other_errors);
    if (val_errors + other_errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

//--- bench/tb_clock_gen.sv
// 8 ns clock from time zero; reset is low until the 16th rising edge and released on it
`timescale 1ns/1ps

module tb_clock_gen
(
  output logic clk_o,
  output logic reset_n_o
);

  // Half period of 4 ns
  initial
  begin
    clk_o = 1'b0;
    forever
      #4 clk_o = ~clk_o;
  end

  // Reset held for 16 cycles
  initial
  begin
    reset_n_o = 1'b0;
    repeat (16) @(posedge clk_o);
    reset_n_o <= 1'b1;
  end

endmodule

//--- src/cv_bus_top.sv
// Colecovision bus pipeline; latency is 3 edges, 4 for M1, and responses cannot be stalled
`timescale 1ns/1ps

module cv_bus_top
(
  input  logic                            clk_i,
  input  logic                            reset_n_s,
  // CPU request and response
  input  logic                            req_valid_i,
  output logic                            req_ready_o,
  input  logic [cv_bus_pkg::addr_w-1:0]   req_addr_i,
  input  logic                            req_io_i,
  input  logic                            req_wr_i,
  input  logic                            req_m1_i,
  input  logic [cv_bus_pkg::data_w-1:0]   req_wdata_i,
  output logic                            resp_valid_o,
  output logic [cv_bus_pkg::data_w-1:0]   resp_rdata_o,
  // Cartridge size
  input  logic [cv_bus_pkg::page_w-1:0]   cart_pages_i,
  // Memories
  output logic                            bios_ce_n_o,
  output logic [cv_bus_pkg::bios_a_w-1:0] bios_a_o,
  input  logic [cv_bus_pkg::data_w-1:0]   bios_d_i,
  output logic                            ram_ce_n_o,
  output logic                            ram_we_n_o,
  output logic [cv_bus_pkg::ram_a_w-1:0]  ram_a_o,
  input  logic [cv_bus_pkg::data_w-1:0]   ram_d_i,
  output logic                            cart_ce_n_o,
  output logic [cv_bus_pkg::cart_a_w-1:0] cart_a_o,
  input  logic [cv_bus_pkg::data_w-1:0]   cart_d_i,
  // I/O chips
  output logic                            vdp_r_n_o,
  output logic                            vdp_w_n_o,
  output logic                            vdp_mode_o,
  input  logic [cv_bus_pkg::data_w-1:0]   vdp_d_i,
  output logic                            psg_we_n_o,
  output logic                            ctrl_r_n_o,
  input  logic [cv_bus_pkg::data_w-1:0]   ctrl_d_i,
  output logic [cv_bus_pkg::data_w-1:0]   periph_d_o
);

  import cv_bus_pkg::*;

  // Request stage to decode
  logic              stg_valid;
  logic [addr_w-1:0] stg_addr;
  logic              stg_io;
  logic              stg_wr;
  logic [data_w-1:0] stg_wdata;

  // Decode to merge
  logic              dec_valid;
  logic              dec_wr;
  dev_sel_t          dec_sel;

  // --------------------
  // Stage 1, request and M1 wait
  // --------------------
  cv_req_stage i_req_stage (
    .clk_i        (clk_i),
    .reset_n_s    (reset_n_s),
    .req_valid_i  (req_valid_i),
    .req_addr_i   (req_addr_i),
    .req_io_i     (req_io_i),
    .req_wr_i     (req_wr_i),
    .req_m1_i     (req_m1_i),
    .req_wdata_i  (req_wdata_i),
    .req_ready_o  (req_ready_o),
    .stg_valid_o  (stg_valid),
    .stg_addr_o   (stg_addr),
    .stg_io_o     (stg_io),
    .stg_wr_o     (stg_wr),
    .stg_wdata_o  (stg_wdata)
  );

  // Stage 2, decode and device strobes
  cv_addr_decode i_addr_decode (
    .clk_i        (clk_i),
    .reset_n_s    (reset_n_s),
    .stg_valid_i  (stg_valid),
    .stg_addr_i   (stg_addr),
    .stg_io_i     (stg_io),
    .stg_wr_i     (stg_wr),
    .stg_wdata_i  (stg_wdata),
    .cart_pages_i (cart_pages_i),
    .bios_ce_n_o  (bios_ce_n_o),
    .bios_a_o     (bios_a_o),
    .ram_ce_n_o   (ram_ce_n_o),
    .ram_we_n_o   (ram_we_n_o),
    .ram_a_o      (ram_a_o),
    .cart_ce_n_o  (cart_ce_n_o),
    .cart_a_o     (cart_a_o),
    .vdp_r_n_o    (vdp_r_n_o),
    .vdp_w_n_o    (vdp_w_n_o),
    .vdp_mode_o   (vdp_mode_o),
    .psg_we_n_o   (psg_we_n_o),
    .ctrl_r_n_o   (ctrl_r_n_o),
    .periph_d_o   (periph_d_o),
    .dec_valid_o  (dec_valid),
    .dec_wr_o     (dec_wr),
    .dec_sel_o    (dec_sel)
  );

  // Stage 3, read data merge
  cv_read_merge i_read_merge (
    .clk_i        (clk_i),
    .reset_n_s    (reset_n_s),
    .dec_valid_i  (dec_valid),
    .dec_wr_i     (dec_wr),
    .dec_sel_i    (dec_sel),
    .bios_d_i     (bios_d_i),
    .ram_d_i      (ram_d_i),
    .cart_d_i     (cart_d_i),
    .vdp_d_i      (vdp_d_i),
    .ctrl_d_i     (ctrl_d_i),
    .resp_valid_o (resp_valid_o),
    .resp_rdata_o (resp_rdata_o)
  );

endmodule

//--- src/cv_read_merge.sv
// Read data merge; device data must be stable in the cycle where dec_valid_i is high
`timescale 1ns/1ps

module cv_read_merge
(
  input  logic                          clk_i,
  input  logic                          reset_n_s,
  input  logic                          dec_valid_i,
  input  logic                          dec_wr_i,
  input  cv_bus_pkg::dev_sel_t          dec_sel_i,
  input  logic [cv_bus_pkg::data_w-1:0] bios_d_i,
  input  logic [cv_bus_pkg::data_w-1:0] ram_d_i,
  input  logic [cv_bus_pkg::data_w-1:0] cart_d_i,
  input  logic [cv_bus_pkg::data_w-1:0] vdp_d_i,
  input  logic [cv_bus_pkg::data_w-1:0] ctrl_d_i,
  output logic                          resp_valid_o,
  output logic [cv_bus_pkg::data_w-1:0] resp_rdata_o
);

  import cv_bus_pkg::*;

  // Masked sources
  logic [data_w-1:0] d_bios_s;
  logic [data_w-1:0] d_ram_s;
  logic [data_w-1:0] d_cart_s;
  logic [data_w-1:0] d_vdp_s;
  logic [data_w-1:0] d_ctrl_s;
  logic [data_w-1:0] merged_s;

  // --------------------
  // Source masking
  // --------------------
  always_comb
  begin
    d_bios_s = d_inact;
    d_ram_s  = d_inact;
    d_cart_s = d_inact;
    d_vdp_s  = d_inact;
    d_ctrl_s = d_inact;
    // A write reads back as an idle bus
    if (!dec_wr_i)
    begin
      case (dec_sel_i)
        bios:    d_bios_s = bios_d_i;
        ram:     d_ram_s  = ram_d_i;
        cart:    d_cart_s = cart_d_i;
        vdp:     d_vdp_s  = vdp_d_i;
        ctrl:    d_ctrl_s = ctrl_d_i;
        default: ;
      endcase
    end
  end

  // Wired-AND of the bus, unmapped reads give all ones
  assign merged_s = d_bios_s & d_ram_s & d_cart_s & d_vdp_s & d_ctrl_s;

  // Response valid
  always_ff @(posedge clk_i or negedge reset_n_s)
  begin
    if (!reset_n_s)
      resp_valid_o <= 1'b0;
    else
      resp_valid_o <= dec_valid_i;
  end

  // Response data
  always_ff @(posedge clk_i)
  begin
    if (dec_valid_i)
      resp_rdata_o <= merged_s;
  end

  // Decode never selects a source for a write
  assert property (@(posedge clk_i) disable iff (!reset_n_s)
    (dec_valid_i && dec_wr_i) |-> (dec_sel_i == none));

endmodule

//--- src/cv_addr_decode.sv
// Registered map decode; strobes last one cycle per request and devices must sample at its end
`timescale 1ns/1ps

module cv_addr_decode
(
  input  logic                            clk_i,
  input  logic                            reset_n_s,
  input  logic                            stg_valid_i,
  input  logic [cv_bus_pkg::addr_w-1:0]   stg_addr_i,
  input  logic                            stg_io_i,
  input  logic                            stg_wr_i,
  input  logic [cv_bus_pkg::data_w-1:0]   stg_wdata_i,
  input  logic [cv_bus_pkg::page_w-1:0]   cart_pages_i,
  output logic                            bios_ce_n_o,
  output logic [cv_bus_pkg::bios_a_w-1:0] bios_a_o,
  output logic                            ram_ce_n_o,
  output logic                            ram_we_n_o,
  output logic [cv_bus_pkg::ram_a_w-1:0]  ram_a_o,
  output logic                            cart_ce_n_o,
  output logic [cv_bus_pkg::cart_a_w-1:0] cart_a_o,
  output logic                            vdp_r_n_o,
  output logic                            vdp_w_n_o,
  output logic                            vdp_mode_o,
  output logic                            psg_we_n_o,
  output logic                            ctrl_r_n_o,
  output logic [cv_bus_pkg::data_w-1:0]   periph_d_o,
  output logic                            dec_valid_o,
  output logic                            dec_wr_o,
  output cv_bus_pkg::dev_sel_t            dec_sel_o
);

  import cv_bus_pkg::*;

  // Cycle type
  logic mem_rd;
  logic mem_wr;
  logic io_rd;
  logic io_wr;

  // Range hits
  logic hit_bios;
  logic hit_ram;
  logic hit_cart;
  logic hit_paged;
  logic hit_page_sel;
  logic hit_vdp;
  logic hit_psg;

  // Page register and the page used for this request
  logic [page_w-1:0] page_q;
  logic [page_w-1:0] page_s;

  // Selection stage that lines up with the strobes
  dev_sel_t sel_s;
  dev_sel_t sel_q;
  logic     sel_valid_q;
  logic     sel_wr_q;

  assign mem_rd = stg_valid_i & ~stg_io_i & ~stg_wr_i;
  assign mem_wr = stg_valid_i & ~stg_io_i &  stg_wr_i;
  assign io_rd  = stg_valid_i &  stg_io_i & ~stg_wr_i;
  assign io_wr  = stg_valid_i &  stg_io_i &  stg_wr_i;

  // --------------------
  // Range decode
  // --------------------
  // BIOS and RAM are both 8 KB regions
  assign hit_bios     = stg_addr_i[addr_w-1:bios_a_w] == bios_base[addr_w-1:bios_a_w];
  assign hit_ram      = stg_addr_i[addr_w-1:bios_a_w] == ram_base[addr_w-1:bios_a_w];
  assign hit_cart     = stg_addr_i[addr_w-1] == cart_base[addr_w-1];
  assign hit_paged    = stg_addr_i[addr_w-1:14] == cart_paged_base[addr_w-1:14];
  assign hit_page_sel = stg_addr_i[addr_w-1:6] == page_sel_base[addr_w-1:6];
  // I/O ports compare on bits 7:5
  assign hit_vdp      = stg_addr_i[7:5] == io_vdp_base[7:5];
  assign hit_psg      = stg_addr_i[7:5] == io_psg_base[7:5];

  // Lower window is fixed to the last page
  assign page_s = hit_paged ? page_q : cart_pages_i;

  // Writes never select a read data source
  always_comb
  begin
    sel_s = none;
    if (mem_rd && hit_bios)
      sel_s = bios;
    else if (mem_rd && hit_ram)
      sel_s = ram;
    else if (mem_rd && hit_cart)
      sel_s = cart;
    else if (io_rd && hit_vdp)
      sel_s = vdp;
    else if (io_rd && hit_psg)
      sel_s = ctrl;
  end

  // --------------------
  // Strobes and pipeline
  // --------------------
  always_ff @(posedge clk_i or negedge reset_n_s)
  begin
    if (!reset_n_s)
    begin
      bios_ce_n_o <= 1'b1;
      ram_ce_n_o  <= 1'b1;
      ram_we_n_o  <= 1'b1;
      cart_ce_n_o <= 1'b1;
      vdp_r_n_o   <= 1'b1;
      vdp_w_n_o   <= 1'b1;
      psg_we_n_o  <= 1'b1;
      ctrl_r_n_o  <= 1'b1;
      page_q      <= '0;
      sel_valid_q <= 1'b0;
      sel_wr_q    <= 1'b0;
      sel_q       <= none;
      dec_valid_o <= 1'b0;
      dec_wr_o    <= 1'b0;
      dec_sel_o   <= none;
    end
    else
    begin
      // ROM ranges only strobe on reads
      bios_ce_n_o <= ~(mem_rd & hit_bios);
      ram_ce_n_o  <= ~((mem_rd | mem_wr) & hit_ram);
      ram_we_n_o  <= ~(mem_wr & hit_ram);
      cart_ce_n_o <= ~(mem_rd & hit_cart);
      vdp_r_n_o   <= ~(io_rd & hit_vdp);
      vdp_w_n_o   <= ~(io_wr & hit_vdp);
      psg_we_n_o  <= ~(io_wr & hit_psg);
      ctrl_r_n_o  <= ~(io_rd & hit_psg);
      // Page select read limited to the pages the cartridge has
      if (mem_rd && hit_page_sel)
        page_q <= stg_addr_i[page_w-1:0] & cart_pages_i;
      sel_valid_q <= stg_valid_i;
      sel_wr_q    <= stg_valid_i & stg_wr_i;
      sel_q       <= sel_s;
      // Second step lines up with the device data
      dec_valid_o <= sel_valid_q;
      dec_wr_o    <= sel_wr_q;
      dec_sel_o   <= sel_q;
    end
  end

  // Device address and write data
  always_ff @(posedge clk_i)
  begin
    if (stg_valid_i)
    begin
      bios_a_o   <= stg_addr_i[bios_a_w-1:0];
      ram_a_o    <= stg_addr_i[ram_a_w-1:0];
      cart_a_o   <= {page_s, stg_addr_i[cart_a_w-page_w-1:0]};
      vdp_mode_o <= stg_addr_i[0];
      periph_d_o <= stg_wdata_i;
    end
  end

  // At most one chip select, read or write strobe per cycle
  assert property (@(posedge clk_i) disable iff (!reset_n_s)
    $onehot0(~{bios_ce_n_o, ram_ce_n_o, cart_ce_n_o, vdp_r_n_o,
               vdp_w_n_o, psg_we_n_o, ctrl_r_n_o}));

endmodule

//--- src/cv_req_stage.sv
// Request register with M1 wait; the CPU side must hold its request fields while ready is low
`timescale 1ns/1ps

module cv_req_stage
(
  input  logic                          clk_i,
  input  logic                          reset_n_s,
  input  logic                          req_valid_i,
  input  logic [cv_bus_pkg::addr_w-1:0] req_addr_i,
  input  logic                          req_io_i,
  input  logic                          req_wr_i,
  input  logic                          req_m1_i,
  input  logic [cv_bus_pkg::data_w-1:0] req_wdata_i,
  output logic                          req_ready_o,
  output logic                          stg_valid_o,
  output logic [cv_bus_pkg::addr_w-1:0] stg_addr_o,
  output logic                          stg_io_o,
  output logic                          stg_wr_o,
  output logic [cv_bus_pkg::data_w-1:0] stg_wdata_o
);

  // Held request present
  logic valid_q;
  // M1 wait flip-flop, set for one cycle after an M1 fetch
  logic wait_q;
  logic accept_s;

  // No new request while the M1 wait runs
  assign req_ready_o = ~wait_q;
  assign accept_s    = req_valid_i & req_ready_o;

  // Request is passed on only once the wait is over
  assign stg_valid_o = valid_q & ~wait_q;

  // --------------------
  // Control state
  // --------------------
  always_ff @(posedge clk_i or negedge reset_n_s)
  begin
    if (!reset_n_s)
    begin
      valid_q <= 1'b0;
      wait_q  <= 1'b0;
    end
    else if (wait_q)
    begin
      // Wait ends, held request stays for decode
      wait_q <= 1'b0;
    end
    else
    begin
      valid_q <= accept_s;
      wait_q  <= accept_s & req_m1_i;
    end
  end

  // Request fields, loaded on acceptance only
  always_ff @(posedge clk_i)
  begin
    if (accept_s)
    begin
      stg_addr_o  <= req_addr_i;
      stg_io_o    <= req_io_i;
      stg_wr_o    <= req_wr_i;
      stg_wdata_o <= req_wdata_i;
    end
  end

  // An M1 fetch blocks exactly the next edge, then ready returns
  assert property (@(posedge clk_i) disable iff (!reset_n_s)
    (accept_s && req_m1_i) |=> !req_ready_o ##1 req_ready_o);

  // CPU side keeps a stalled request stable
  assert property (@(posedge clk_i) disable iff (!reset_n_s)
    (req_valid_i && !req_ready_o) |=> (req_valid_i && $stable(req_addr_i)
                                       && $stable(req_wr_i) && $stable(req_io_i)));

endmodule

//--- src/cv_bus_pkg.sv
// Colecovision bus constants; I/O ports decode on address bits 7:5 only, the upper byte is ignored
package cv_bus_pkg;

  // --------------------
  // Bus widths
  // --------------------

  // CPU address and data
  localparam int addr_w = 16;
  localparam int data_w = 8;

  // Value of a source that is not selected, the board pulls the bus high
  localparam logic [data_w-1:0] d_inact = 8'hFF;

  // Device address widths
  localparam int bios_a_w = 13;
  localparam int ram_a_w  = 10;
  localparam int cart_a_w = 20;
  localparam int page_w   = 6;

  // --------------------
  // Memory map
  // --------------------

  // BIOS ROM, 8 KB
  localparam logic [addr_w-1:0] bios_base       = 16'h0000;
  // CPU RAM, 1 KB mirrored over 8 KB
  localparam logic [addr_w-1:0] ram_base        = 16'h6000;
  // Cartridge, fixed window on the last page
  localparam logic [addr_w-1:0] cart_base       = 16'h8000;
  // Cartridge, window behind the page register
  localparam logic [addr_w-1:0] cart_paged_base = 16'hC000;
  // Reads here load the page register
  localparam logic [addr_w-1:0] page_sel_base   = 16'hFFC0;

  // --------------------
  // I/O map
  // --------------------

  // VDP data and control, mode on bit 0
  localparam logic [7:0] io_vdp_base = 8'hA0;
  // PSG on writes, controller on reads
  localparam logic [7:0] io_psg_base = 8'hE0;

  // Source of the read data, travels from decode to merge
  typedef enum logic [2:0] {
    none,
    bios,
    ram,
    cart,
    vdp,
    ctrl
  } dev_sel_t;

endpackage
